/* hw/regRead_settings.svh */
// widths and counts shared by the register-read stage, include before any stage source
`ifndef REGREAD_SETTINGS_SVH
`define REGREAD_SETTINGS_SVH

// issue and bypass lanes
`define NUM_LANES 4

// physical register file
`define NUM_PHYS 64
`define PHYS_LOG 6
`define DATA_W   32

// branch checkpoints
`define NUM_CKPT 4
`define CKPT_LOG 2

// low registers that start out ready after reset
`define NUM_ARCH 32

`define NUM_READ (2 * `NUM_LANES) // two sources per lane

`endif

/* hw/regReadPkg.sv */
// packet and tag types passed between the register-read blocks, referenced as regReadPkg::name
`include "regRead_settings.svh"

package regReadPkg;

  typedef logic [`PHYS_LOG-1:0] physTag_t;
  typedef logic [`DATA_W-1:0]   regData_t;
  typedef logic [`NUM_CKPT-1:0] ckptMask_t;

  // instruction coming from issue
  typedef struct packed {
    logic      valid;
    ckptMask_t mask;     // unresolved branches this op sits behind
    physTag_t  src1;
    physTag_t  src2;
    physTag_t  dest;
  } issuePkt_t;

  // one result lane from the functional units
  typedef struct packed {
    logic     valid;
    physTag_t dest;
    regData_t data;
  } bypassPkt_t;

  // instruction handed to execute
  typedef struct packed {
    logic      valid;
    ckptMask_t mask;
    physTag_t  dest;
    regData_t  src1Data;
    regData_t  src2Data;
  } readPkt_t;

  // branch resolution from execute
  typedef struct packed {
    logic                verified;
    logic                mispredict;
    logic [`CKPT_LOG-1:0] ckptId;
  } ctrlEvent_t;

  // unmap or wakeup request
  typedef struct packed {
    logic     valid;
    physTag_t tag;
  } tagReq_t;

endpackage

/* hw/physRegFile.sv */
// physical register file, four bypass write ports and eight combinational read ports
`timescale 1ns/10ps
`include "regRead_settings.svh"

module physRegFile (
  input  logic                   clk,
  input  regReadPkg::bypassPkt_t bypass_i [0:`NUM_LANES-1],
  input  logic                   recoverFlag_i,
  input  regReadPkg::physTag_t   readTag_i [0:`NUM_READ-1],
  output regReadPkg::regData_t   readData_o [0:`NUM_READ-1]
);

  regReadPkg::regData_t regFile [0:`NUM_PHYS-1];
  logic [`NUM_LANES-1:0] writeEn;

  // results are dropped while the core is recovering
  for (genvar w = 0; w < `NUM_LANES; w++)
  begin : gWe
    assign writeEn[w] = bypass_i[w].valid & ~recoverFlag_i;
  end

  always_ff @(posedge clk)
  begin
    for (int w = 0; w < `NUM_LANES; w++)
    begin
      if (writeEn[w])
        regFile[bypass_i[w].dest] <= bypass_i[w].data;
    end
  end

  // same-cycle writes are not seen here, operandBypass covers them
  for (genvar r = 0; r < `NUM_READ; r++)
  begin : gRead
    assign readData_o[r] = regFile[readTag_i[r]];
  end

  // rename never hands one tag to two producers finishing together
  for (genvar a = 0; a < `NUM_LANES; a++)
  begin : gChkA
    for (genvar b = a + 1; b < `NUM_LANES; b++)
    begin : gChkB
      writeConflict: assert property (
        @(posedge clk) (writeEn[a] && writeEn[b]) |-> (bypass_i[a].dest != bypass_i[b].dest)
      )
      else $error("two write lanes hit tag %0d", bypass_i[a].dest);
    end
  end

endmodule

/* hw/operandBypass.sv */
// compares every source tag against the bypass lanes and picks bypass data or the file word
`timescale 1ns/10ps
`include "regRead_settings.svh"

module operandBypass (
  input  regReadPkg::issuePkt_t  issue_i [0:`NUM_LANES-1],
  input  regReadPkg::bypassPkt_t bypass_i [0:`NUM_LANES-1],
  input  regReadPkg::regData_t   fileData_i [0:`NUM_READ-1],
  output regReadPkg::regData_t   operand_o [0:`NUM_READ-1]
);

  // source s belongs to lane s/2, even is src1 and odd is src2
  for (genvar s = 0; s < `NUM_READ; s++)
  begin : gSrc
    regReadPkg::physTag_t srcTag;
    logic [`NUM_LANES-1:0] matchVec;
    logic                  oneHit;
    regReadPkg::regData_t  hitData;

    assign srcTag = (s % 2 == 0) ? issue_i[s/2].src1 : issue_i[s/2].src2;

    always_comb
    begin
      hitData = '0;
      for (int b = 0; b < `NUM_LANES; b++)
      begin
        matchVec[b] = bypass_i[b].valid && (bypass_i[b].dest == srcTag);
        if (matchVec[b])
          hitData = hitData | bypass_i[b].data;
      end
    end

    // exactly one bit set
    assign oneHit = (matchVec != '0) && ((matchVec & (matchVec - 1'b1)) == '0);

    assign operand_o[s] = oneHit ? hitData : fileData_i[s];

    // producers of one tag never finish in the same cycle
    always_comb
    begin
      multiMatch: assert final ($isunknown(matchVec) || (matchVec & (matchVec - 1'b1)) == '0)
      else $error("source %0d matched bypass lanes %b", s, matchVec);
    end
  end

endmodule

/* hw/operandLatch.sv */
// applies the mispredict squash and registers the outgoing packets with one cycle of latency
`timescale 1ns/10ps
`include "regRead_settings.svh"

module operandLatch (
  input  logic                   clk,
  input  logic                   rstN_i,
  input  regReadPkg::issuePkt_t  issue_i [0:`NUM_LANES-1],
  input  regReadPkg::regData_t   operand_i [0:`NUM_READ-1],
  input  regReadPkg::ctrlEvent_t ctrl_i,
  output regReadPkg::readPkt_t   readOut_o [0:`NUM_LANES-1]
);

  logic                  mispredict;
  logic [`NUM_LANES-1:0] squash;
  regReadPkg::readPkt_t  readQ [0:`NUM_LANES-1];

  assign mispredict = ctrl_i.verified & ctrl_i.mispredict;

  for (genvar l = 0; l < `NUM_LANES; l++)
  begin : gLane
    assign squash[l] = mispredict & issue_i[l].mask[ctrl_i.ckptId]; // op is on the wrong path

    always_ff @(posedge clk)
    begin
      if (!rstN_i)
        readQ[l].valid <= 1'b0;
      else
        readQ[l].valid <= issue_i[l].valid & ~squash[l];
    end

    always_ff @(posedge clk)
    begin
      readQ[l].mask     <= issue_i[l].mask;
      readQ[l].dest     <= issue_i[l].dest;
      readQ[l].src1Data <= operand_i[2*l];
      readQ[l].src2Data <= operand_i[2*l+1];
    end

    assign readOut_o[l] = readQ[l];

    squashHolds: assert property (
      @(posedge clk) disable iff (!rstN_i)
        (ctrl_i.verified && ctrl_i.mispredict && issue_i[l].mask[ctrl_i.ckptId])
          |=> !readOut_o[l].valid
    )
    else $error("lane %0d issued an op that was squashed", l);
  end

endmodule

/* hw/readyTable.sv */
// one ready bit per physical register, cleared by unmap, set by wakeup, restored on exception
`timescale 1ns/10ps
`include "regRead_settings.svh"

module readyTable (
  input  logic                clk,
  input  logic                rstN_i,
  input  logic                exceptionFlag_i,
  input  regReadPkg::tagReq_t unmap_i [0:`NUM_LANES-1],
  input  regReadPkg::tagReq_t wakeup_i [0:`NUM_LANES-1],
  output logic [`NUM_PHYS-1:0] phyRegRdy_o
);

  // architectural registers start mapped and ready
  localparam logic [`NUM_PHYS-1:0] RDY_INIT =
    {{(`NUM_PHYS - `NUM_ARCH){1'b0}}, {`NUM_ARCH{1'b1}}};

  logic [`NUM_PHYS-1:0] rdyQ;
  logic [`NUM_PHYS-1:0] rdyNext;

  always_comb
  begin
    rdyNext = rdyQ;
    for (int u = 0; u < `NUM_LANES; u++)
    begin
      if (unmap_i[u].valid)
        rdyNext[unmap_i[u].tag] = 1'b0;
    end
    // sets after clears so a wakeup wins on the same tag
    for (int w = 0; w < `NUM_LANES; w++)
    begin
      if (wakeup_i[w].valid)
        rdyNext[wakeup_i[w].tag] = 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rstN_i || exceptionFlag_i)
      rdyQ <= RDY_INIT;
    else
      rdyQ <= rdyNext;
  end

  assign phyRegRdy_o = rdyQ;

  // rename only frees an arch register after it has been remapped
  for (genvar u = 0; u < `NUM_LANES; u++)
  begin : gChk
    unmapArch: assert property (
      @(posedge clk) disable iff (!rstN_i) unmap_i[u].valid |-> (unmap_i[u].tag >= `NUM_ARCH)
    )
    else $error("unmap lane %0d freed tag %0d", u, unmap_i[u].tag);
  end

endmodule

/* hw/regReadStage.sv */
// register-read stage of the four-wide core, connects file, bypass, latch and ready table
`timescale 1ns/10ps
`include "regRead_settings.svh"

module regReadStage (
  input  logic                   clk,
  input  logic                   rstN_i,
  input  regReadPkg::issuePkt_t  issue_i [0:`NUM_LANES-1],
  input  regReadPkg::bypassPkt_t bypass_i [0:`NUM_LANES-1],
  input  regReadPkg::ctrlEvent_t ctrl_i,
  input  regReadPkg::tagReq_t    unmap_i [0:`NUM_LANES-1],
  input  regReadPkg::tagReq_t    wakeup_i [0:`NUM_LANES-1],
  input  logic                   recoverFlag_i,
  input  logic                   exceptionFlag_i,
  output regReadPkg::readPkt_t   readOut_o [0:`NUM_LANES-1],
  output logic [`NUM_PHYS-1:0]   phyRegRdy_o
);

  regReadPkg::physTag_t readTag [0:`NUM_READ-1];
  regReadPkg::regData_t fileData [0:`NUM_READ-1];
  regReadPkg::regData_t operand [0:`NUM_READ-1];

  // read port 2*l is src1 of lane l, 2*l+1 is src2
  for (genvar l = 0; l < `NUM_LANES; l++)
  begin : gTag
    assign readTag[2*l]   = issue_i[l].src1;
    assign readTag[2*l+1] = issue_i[l].src2;
  end

  physRegFile physRegFile_i (
    .clk           (clk),
    .bypass_i      (bypass_i),
    .recoverFlag_i (recoverFlag_i),
    .readTag_i     (readTag),
    .readData_o    (fileData)
  );

  operandBypass operandBypass_i (
    .issue_i    (issue_i),
    .bypass_i   (bypass_i),
    .fileData_i (fileData),
    .operand_o  (operand)
  );

  operandLatch operandLatch_i (
    .clk       (clk),
    .rstN_i    (rstN_i),
    .issue_i   (issue_i),
    .operand_i (operand),
    .ctrl_i    (ctrl_i),
    .readOut_o (readOut_o)
  );

  readyTable readyTable_i (
    .clk             (clk),
    .rstN_i          (rstN_i),
    .exceptionFlag_i (exceptionFlag_i),
    .unmap_i         (unmap_i),
    .wakeup_i        (wakeup_i),
    .phyRegRdy_o     (phyRegRdy_o)
  );

endmodule

/* verification/regReadTb.sv */
// testbench for regReadStage that runs directed and random traffic against a shadow model
`timescale 1ns/10ps
`include "regRead_settings.svh"

module regReadTb;

  localparam int CLK_PERIOD    = 100;
  localparam int DRIVE_DLY     = 5;   // inputs change this long after the rising edge
  localparam int RANDOM_CYCLES = 2000;
  localparam int DRAIN_LIMIT   = 20;

  // one cycle of expected outputs
  typedef struct packed {
    regReadPkg::readPkt_t [`NUM_LANES-1:0] pkt;
    logic [`NUM_PHYS-1:0]                  rdy;
  } expItem_t;

  logic clk;
  logic rstN;
  regReadPkg::issuePkt_t  issue [0:`NUM_LANES-1];
  regReadPkg::bypassPkt_t bypass [0:`NUM_LANES-1];
  regReadPkg::ctrlEvent_t ctrl;
  regReadPkg::tagReq_t    unmap [0:`NUM_LANES-1];
  regReadPkg::tagReq_t    wakeup [0:`NUM_LANES-1];
  logic recoverFlag;
  logic exceptionFlag;
  regReadPkg::readPkt_t   readOut [0:`NUM_LANES-1];
  logic [`NUM_PHYS-1:0]   rdy;

  // values for the next cycle as filled in by the tests
  regReadPkg::issuePkt_t  issueN [0:`NUM_LANES-1];
  regReadPkg::bypassPkt_t bypassN [0:`NUM_LANES-1];
  regReadPkg::ctrlEvent_t ctrlN;
  regReadPkg::tagReq_t    unmapN [0:`NUM_LANES-1];
  regReadPkg::tagReq_t    wakeupN [0:`NUM_LANES-1];
  logic recoverN;
  logic exceptionN;

  regReadPkg::regData_t shadowReg [0:`NUM_PHYS-1];
  logic [`NUM_PHYS-1:0] shadowRdy;
  logic [`NUM_PHYS-1:0] resetRdy;

  expItem_t expQ[$];
  string    nameQ[$];
  int       pushed = 0;
  int       compared = 0;
  integer   seed = 58028;

  regReadStage regReadStage_i (
    .clk             (clk),
    .rstN_i          (rstN),
    .issue_i         (issue),
    .bypass_i        (bypass),
    .ctrl_i          (ctrl),
    .unmap_i         (unmap),
    .wakeup_i        (wakeup),
    .recoverFlag_i   (recoverFlag),
    .exceptionFlag_i (exceptionFlag),
    .readOut_o       (readOut),
    .phyRegRdy_o     (rdy)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  function automatic logic [31:0] rnd();
    return $random(seed);
  endfunction

  // expected operand from a single valid bypass hit or else the shadow file
  function automatic regReadPkg::regData_t refOperand(
    input regReadPkg::physTag_t   tag,
    input regReadPkg::bypassPkt_t byp [0:`NUM_LANES-1]
  );
    int                   hits;
    regReadPkg::regData_t hitData;
    hits = 0;
    hitData = '0;
    for (int b = 0; b < `NUM_LANES; b++)
    begin
      if (byp[b].valid && byp[b].dest == tag)
      begin
        hits++;
        hitData = byp[b].data;
      end
    end
    return (hits == 1) ? hitData : shadowReg[tag];
  endfunction

  task automatic stopRun();
    $display("Result: FAILED");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic failValue(input string name, input logic [127:0] expVal,
                           input logic [127:0] actVal);
    $display("FAIL %s expected %h actual %h", name, expVal, actVal);
    stopRun();
  endtask

  task automatic clearInputs();
    for (int l = 0; l < `NUM_LANES; l++)
    begin
      issueN[l]  = '0;
      bypassN[l] = '0;
      unmapN[l]  = '0;
      wakeupN[l] = '0;
    end
    ctrlN      = '0;
    recoverN   = 1'b0;
    exceptionN = 1'b0;
  endtask

  task automatic driveInputs();
    issue         = issueN;
    bypass        = bypassN;
    ctrl          = ctrlN;
    unmap         = unmapN;
    wakeup        = wakeupN;
    recoverFlag   = recoverN;
    exceptionFlag = exceptionN;
  endtask

  // drive one cycle, queue its expected outputs, advance the shadow model
  task automatic applyCycle(input string name);
    expItem_t e;
    logic     misp;
    driveInputs();
    misp = ctrlN.verified & ctrlN.mispredict;
    for (int l = 0; l < `NUM_LANES; l++)
    begin
      e.pkt[l].valid    = issueN[l].valid & ~(misp & issueN[l].mask[ctrlN.ckptId]);
      e.pkt[l].mask     = issueN[l].mask;
      e.pkt[l].dest     = issueN[l].dest;
      e.pkt[l].src1Data = refOperand(issueN[l].src1, bypassN);
      e.pkt[l].src2Data = refOperand(issueN[l].src2, bypassN);
    end
    for (int l = 0; l < `NUM_LANES; l++)
    begin
      if (bypassN[l].valid && !recoverN)
        shadowReg[bypassN[l].dest] = bypassN[l].data;
    end
    if (exceptionN)
      shadowRdy = resetRdy;
    else
    begin
      for (int l = 0; l < `NUM_LANES; l++)
        if (unmapN[l].valid) shadowRdy[unmapN[l].tag] = 1'b0;
      for (int l = 0; l < `NUM_LANES; l++)
        if (wakeupN[l].valid) shadowRdy[wakeupN[l].tag] = 1'b1; // set after clear
    end
    e.rdy = shadowRdy;
    expQ.push_back(e);
    nameQ.push_back(name);
    pushed++;
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  task automatic checkOutputs(input expItem_t e, input string name);
    string laneName;
    for (int l = 0; l < `NUM_LANES; l++)
    begin
      laneName = $sformatf("%s lane %0d", name, l);
      assert (readOut[l].valid === e.pkt[l].valid)
      else failValue({laneName, " valid"}, e.pkt[l].valid, readOut[l].valid);
      if (e.pkt[l].valid)
      begin
        assert (readOut[l] === e.pkt[l])
        else failValue({laneName, " packet"}, e.pkt[l], readOut[l]);
      end
    end
    assert (rdy === e.rdy)
    else failValue({name, " ready"}, e.rdy, rdy);
  endtask

  task automatic checkReset();
    for (int l = 0; l < `NUM_LANES; l++)
    begin
      assert (readOut[l].valid === 1'b0)
      else failValue($sformatf("reset lane %0d valid", l), 1'b0, readOut[l].valid);
    end
    assert (rdy === resetRdy)
    else failValue("reset ready", resetRdy, rdy);
  endtask

  task automatic waitDrain();
    int waitCycles;
    waitCycles = 0;
    while (compared != pushed && waitCycles < DRAIN_LIMIT)
    begin
      @(posedge clk);
      waitCycles++;
    end
    if (compared != pushed)
    begin
      $display("timeout: DUT outputs were not all checked within %0d cycles", DRAIN_LIMIT);
      stopRun();
    end
  endtask

  task automatic randomCycle();
    logic [31:0] r;
    clearInputs();
    for (int l = 0; l < `NUM_LANES; l++)
    begin
      r = rnd();
      bypassN[l].valid = r[0];
      bypassN[l].dest  = regReadPkg::physTag_t'(l * (`NUM_PHYS / `NUM_LANES) + r[4:1]);
      bypassN[l].data  = rnd();
    end
    for (int l = 0; l < `NUM_LANES; l++)
    begin
      r = rnd();
      issueN[l].valid = (r[1:0] != 2'b00);
      issueN[l].mask  = r[5:2];
      issueN[l].src1  = r[11:6];
      issueN[l].src2  = r[17:12];
      issueN[l].dest  = r[23:18];
      if (r[25:24] == 2'b00)
        issueN[l].src1 = bypassN[r[27:26]].dest; // steer toward forwarding
      if (r[29:28] == 2'b00)
        issueN[l].src2 = bypassN[r[31:30]].dest;
    end
    for (int l = 0; l < `NUM_LANES; l++)
    begin
      r = rnd();
      unmapN[l].valid  = (r[1:0] == 2'b00);
      unmapN[l].tag    = regReadPkg::physTag_t'(`NUM_ARCH + r[6:2]);
      wakeupN[l].valid = (r[8:7] == 2'b00);
      wakeupN[l].tag   = r[14:9];
    end
    r = rnd();
    ctrlN      = r[3:0];
    recoverN   = (r[7:4] == 4'd0);
    exceptionN = (r[12:8] == 5'd0);
  endtask

  // an item pushed before edge t is checked at the falling edge after t
  initial
  begin
    expItem_t cur;
    string    curName;
    forever
    begin
      @(posedge clk);
      if (expQ.size() > 0)
      begin
        cur = expQ.pop_front();
        curName = nameQ.pop_front();
        @(negedge clk);
        checkOutputs(cur, curName);
        compared++;
      end
    end
  end

  initial
  begin
    for (int i = 0; i < `NUM_PHYS; i++)
      resetRdy[i] = (i < `NUM_ARCH);
    shadowRdy = resetRdy;
    rstN = 1'b0;
    clearInputs();
    driveInputs();
    repeat (2) @(posedge clk);
    #DRIVE_DLY;
    rstN = 1'b1;
    checkReset();

    // fill every register through the write lanes, then read them back
    for (int c = 0; c < `NUM_PHYS / `NUM_LANES; c++)
    begin
      clearInputs();
      for (int l = 0; l < `NUM_LANES; l++)
      begin
        bypassN[l].valid = 1'b1;
        bypassN[l].dest  = regReadPkg::physTag_t'(c * `NUM_LANES + l);
        bypassN[l].data  = rnd();
      end
      applyCycle("file write");
    end
    for (int c = 0; c < `NUM_PHYS / `NUM_LANES; c++)
    begin
      clearInputs();
      for (int l = 0; l < `NUM_LANES; l++)
      begin
        issueN[l].valid = 1'b1;
        issueN[l].src1  = regReadPkg::physTag_t'(c * `NUM_LANES + l);
        issueN[l].src2  = regReadPkg::physTag_t'(`NUM_PHYS - 1 - (c * `NUM_LANES + l));
        issueN[l].dest  = regReadPkg::physTag_t'(c);
      end
      applyCycle("file read");
    end

    // same-cycle forwarding with the last pass under recovery so the file keeps old data
    for (int c = 0; c < 5; c++)
    begin
      clearInputs();
      for (int l = 0; l < `NUM_LANES; l++)
      begin
        bypassN[l].valid = 1'b1;
        bypassN[l].dest  = regReadPkg::physTag_t'(l * 16 + c);
        bypassN[l].data  = rnd();
      end
      for (int l = 0; l < `NUM_LANES; l++)
      begin
        issueN[l].valid = 1'b1;
        issueN[l].src1  = bypassN[(l + 1) % `NUM_LANES].dest;
        issueN[l].src2  = regReadPkg::physTag_t'(l * 16 + c + 8);
        issueN[l].dest  = regReadPkg::physTag_t'(l);
      end
      recoverN = (c == 4);
      applyCycle(recoverN ? "forward recover" : "forward");
    end
    clearInputs();
    for (int l = 0; l < `NUM_LANES; l++)
    begin
      issueN[l].valid = 1'b1;
      issueN[l].src1  = regReadPkg::physTag_t'(l * 16 + 4); // written only under recovery
      issueN[l].src2  = regReadPkg::physTag_t'(l * 16 + 3);
    end
    applyCycle("read after recover");

    // one mask bit per lane and cases 4 and 5 lack verified or mispredict
    for (int c = 0; c < 6; c++)
    begin
      clearInputs();
      for (int l = 0; l < `NUM_LANES; l++)
      begin
        issueN[l].valid = 1'b1;
        issueN[l].mask  = regReadPkg::ckptMask_t'(1 << l);
        issueN[l].src1  = regReadPkg::physTag_t'(l);
        issueN[l].src2  = regReadPkg::physTag_t'(l + 8);
        issueN[l].dest  = regReadPkg::physTag_t'(l + 32);
      end
      ctrlN.verified   = (c != 4);
      ctrlN.mispredict = (c != 5);
      ctrlN.ckptId     = c[1:0];
      applyCycle("squash");
    end

    // ready table wakeup, unmap, same-cycle pair and exception restore
    clearInputs();
    wakeupN[0] = '{valid: 1'b1, tag: 6'd40};
    wakeupN[1] = '{valid: 1'b1, tag: 6'd41};
    applyCycle("ready wakeup");
    clearInputs();
    unmapN[0] = '{valid: 1'b1, tag: 6'd40};
    applyCycle("ready unmap");
    clearInputs();
    unmapN[1]  = '{valid: 1'b1, tag: 6'd41};
    wakeupN[2] = '{valid: 1'b1, tag: 6'd41};
    applyCycle("ready pair");
    clearInputs();
    exceptionN = 1'b1;
    applyCycle("ready exception");

    for (int c = 0; c < RANDOM_CYCLES; c++)
    begin
      randomCycle();
      applyCycle("random");
    end

    clearInputs();
    applyCycle("idle");
    waitDrain();

    $display("Result: PASSED");
    $finish;
  end

endmodule

/* build.f */
+incdir+hw
hw/regReadPkg.sv
hw/physRegFile.sv
hw/operandBypass.sv
hw/operandLatch.sv
hw/readyTable.sv
hw/regReadStage.sv
verification/regReadTb.sv
